// File: Bender.yml
package:
  name: tcb_mem

sources:
  # package and rtl
  - include_dirs:
      - source
    files:
      - source/tcb_pkg.sv
      - source/tcb_req_reg.sv
      - source/tcb_riscv2memory.sv
      - source/tcb_mem_sram.sv
      - source/tcb_rsp_fmt.sv
      - source/tcb_mem_top.sv
  # testbench and bound assertions
  - target: test
    include_dirs:
      - source
    files:
      - tb/tcb_mem_properties.sv
      - tb/tcb_mem_tb.sv

// File: source/tcb_cfg.svh
// tcb data memory subsystem, global sizing constants
`ifndef TCB_CFG_SVH
`define TCB_CFG_SVH

// byte address width
`define TCB_ADR_W 16

// data bus width, fixed at one 32-bit word
`define TCB_DAT_W 32

// byte lanes per word
// lane index is log2 of this wide
`define TCB_BEN 4

// memory size in bytes
// anything at or above this address is out of range
`define TCB_MEM_BYTES 1024

`endif

// File: source/tcb_mem_sram.sv
// tcb single-port sram model, byte write enables and one-cycle read latency
`timescale 1ns/1ps
`include "tcb_cfg.svh"

module tcb_mem_sram (
  // clock
  input  logic                  sub,
  // access port
  input  logic                  mem_vld,
  input  logic                  mem_wen,
  input  logic [`TCB_BEN-1:0]   mem_ben,
  input  logic [`TCB_ADR_W-1:0] mem_adr,
  input  logic [`TCB_DAT_W-1:0] mem_wdt,
  // read data, valid the cycle after a read
  output logic [`TCB_DAT_W-1:0] mem_rdt
);

  localparam int unsigned DAT_W = `TCB_DAT_W;
  localparam int unsigned BEN   = `TCB_BEN;
  localparam int unsigned LW    = $clog2(BEN);
  localparam int unsigned DEPTH = `TCB_MEM_BYTES / BEN;
  localparam int unsigned IW    = $clog2(DEPTH);

  //////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////

  // word array, contents undefined after power up
  logic [DAT_W-1:0] mem [DEPTH];

  // word index, drop lane bits
  // upper address bits are always zero here, range checked upstream
  logic [IW-1:0] idx;

  assign idx = mem_adr[IW+LW-1:LW];

  //////////////////////////////////////////////////////////////////////
  // write
  //////////////////////////////////////////////////////////////////////

  // only enabled lanes change
  always_ff @(posedge sub) begin
    if (mem_vld && mem_wen) begin
      for (int unsigned b = 0; b < BEN; b++) begin
        if (mem_ben[b]) begin
          mem[idx][8*b +: 8] <= mem_wdt[8*b +: 8];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read
  //////////////////////////////////////////////////////////////////////

  // full word out, lane select happens in the converter
  // output holds between reads
  always_ff @(posedge sub) begin
    if (mem_vld && !mem_wen) begin
      mem_rdt <= mem[idx];
    end
  end

endmodule

// File: source/tcb_mem_top.sv
// tcb data memory subsystem top, request stage, converter, sram and response formatter
`timescale 1ns/1ps
`include "tcb_cfg.svh"

module tcb_mem_top (
  // clock and reset
  input  logic                  sub,
  input  logic                  rst_n,
  // processor request
  input  logic                  req_vld,
  input  tcb_pkg::tcb_op_e      req_op,
  input  tcb_pkg::tcb_siz_e     req_siz,
  input  tcb_pkg::tcb_ndn_e     req_ndn,
  input  logic                  req_uns,
  input  logic [`TCB_ADR_W-1:0] req_adr,
  input  logic [`TCB_DAT_W-1:0] req_wdt,
  // processor response, two cycles after the request
  output logic                  rsp_vld,
  output logic [`TCB_DAT_W-1:0] rsp_rdt,
  output logic                  rsp_err
);

  // registered request
  logic                  q_vld;
  tcb_pkg::tcb_op_e      q_op;
  tcb_pkg::tcb_siz_e     q_siz;
  tcb_pkg::tcb_ndn_e     q_ndn;
  logic                  q_uns;
  logic [`TCB_ADR_W-1:0] q_adr;
  logic [`TCB_DAT_W-1:0] q_wdt;
  logic                  q_oor;

  // memory port
  logic                  mem_vld;
  logic                  mem_wen;
  logic [`TCB_BEN-1:0]   mem_ben;
  logic [`TCB_ADR_W-1:0] mem_adr;
  logic [`TCB_DAT_W-1:0] mem_wdt;
  logic [`TCB_DAT_W-1:0] mem_rdt;

  // realigned response
  logic                  al_vld;
  logic [`TCB_DAT_W-1:0] al_rdt;
  tcb_pkg::tcb_siz_e     al_siz;
  logic                  al_uns;
  logic                  al_err;
  tcb_pkg::tcb_op_e      al_op;

  //////////////////////////////////////////////////////////////////////
  // pipeline
  //////////////////////////////////////////////////////////////////////

  tcb_req_reg u_req (
    .sub     (sub),     .rst_n   (rst_n),
    .req_vld (req_vld), .req_op  (req_op),  .req_siz (req_siz),
    .req_ndn (req_ndn), .req_uns (req_uns), .req_adr (req_adr),
    .req_wdt (req_wdt),
    .q_vld   (q_vld),   .q_op    (q_op),    .q_siz   (q_siz),
    .q_ndn   (q_ndn),   .q_uns   (q_uns),   .q_adr   (q_adr),
    .q_wdt   (q_wdt),   .q_oor   (q_oor)
  );

  tcb_riscv2memory u_cnv (
    .sub     (sub),     .rst_n   (rst_n),
    .q_vld   (q_vld),   .q_op    (q_op),    .q_siz   (q_siz),
    .q_ndn   (q_ndn),   .q_uns   (q_uns),   .q_adr   (q_adr),
    .q_wdt   (q_wdt),   .q_oor   (q_oor),
    .mem_vld (mem_vld), .mem_wen (mem_wen), .mem_ben (mem_ben),
    .mem_adr (mem_adr), .mem_wdt (mem_wdt), .mem_rdt (mem_rdt),
    .al_vld  (al_vld),  .al_rdt  (al_rdt),  .al_siz  (al_siz),
    .al_uns  (al_uns),  .al_err  (al_err),  .al_op   (al_op)
  );

  tcb_mem_sram u_mem (
    .sub     (sub),
    .mem_vld (mem_vld), .mem_wen (mem_wen), .mem_ben (mem_ben),
    .mem_adr (mem_adr), .mem_wdt (mem_wdt), .mem_rdt (mem_rdt)
  );

  tcb_rsp_fmt u_fmt (
    .al_vld  (al_vld),  .al_rdt  (al_rdt),  .al_siz  (al_siz),
    .al_uns  (al_uns),  .al_err  (al_err),  .al_op   (al_op),
    .rsp_vld (rsp_vld), .rsp_rdt (rsp_rdt), .rsp_err (rsp_err)
  );

endmodule

// File: source/tcb_pkg.sv
// tcb data memory subsystem, shared enum types for opcode, size and byte order
package tcb_pkg;

  //////////////////////////////////////////////////////////////////////
  // request field encodings
  //////////////////////////////////////////////////////////////////////

  // access direction
  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } tcb_op_e;

  // access size as log2 of byte count
  // code 2'b11 is illegal, decoded as misaligned
  typedef enum logic [1:0] {
    siz_byte = 2'd0,
    siz_half = 2'd1,
    siz_word = 2'd2
  } tcb_siz_e;

  // byte order of the item within its lanes
  typedef enum logic {
    ndn_little = 1'b0,
    ndn_big    = 1'b1
  } tcb_ndn_e;

endpackage

// File: source/tcb_req_reg.sv
// tcb request input stage, registers the request and flags out-of-range addresses
`timescale 1ns/1ps
`include "tcb_cfg.svh"

module tcb_req_reg (
  // clock and reset
  input  logic                 sub,
  input  logic                 rst_n,
  // processor side request
  input  logic                 req_vld,
  input  tcb_pkg::tcb_op_e     req_op,
  input  tcb_pkg::tcb_siz_e    req_siz,
  input  tcb_pkg::tcb_ndn_e    req_ndn,
  input  logic                 req_uns,
  input  logic [`TCB_ADR_W-1:0] req_adr,
  input  logic [`TCB_DAT_W-1:0] req_wdt,
  // registered request towards the converter
  output logic                 q_vld,
  output tcb_pkg::tcb_op_e     q_op,
  output tcb_pkg::tcb_siz_e    q_siz,
  output tcb_pkg::tcb_ndn_e    q_ndn,
  output logic                 q_uns,
  output logic [`TCB_ADR_W-1:0] q_adr,
  output logic [`TCB_DAT_W-1:0] q_wdt,
  output logic                 q_oor
);

  localparam int unsigned ADR_W = `TCB_ADR_W;

  // range check against memory size
  logic oor;

  //////////////////////////////////////////////////////////////////////
  // address range
  //////////////////////////////////////////////////////////////////////

  // memory occupies the bottom of the address space
  assign oor = (req_adr >= ADR_W'(`TCB_MEM_BYTES));

  //////////////////////////////////////////////////////////////////////
  // pipeline register
  //////////////////////////////////////////////////////////////////////

  // strobe, the only control bit here
  always_ff @(posedge sub or negedge rst_n) begin
    if (!rst_n) begin
      q_vld <= 1'b0;
    end else begin
      q_vld <= req_vld;
    end
  end

  // fields only sampled on a strobe
  // held otherwise, downstream ignores them without q_vld
  always_ff @(posedge sub) begin
    if (req_vld) begin
      q_op  <= req_op;
      q_siz <= req_siz;
      q_ndn <= req_ndn;
      q_uns <= req_uns;
      q_adr <= req_adr;
      q_wdt <= req_wdt;
      q_oor <= oor;
    end
  end

endmodule

// File: source/tcb_riscv2memory.sv
// tcb riscv to memory converter, alignment check, lane mapping and read realignment
`timescale 1ns/1ps
`include "tcb_cfg.svh"

module tcb_riscv2memory (
  // clock and reset
  input  logic                  sub,
  input  logic                  rst_n,
  // registered request
  input  logic                  q_vld,
  input  tcb_pkg::tcb_op_e      q_op,
  input  tcb_pkg::tcb_siz_e     q_siz,
  input  tcb_pkg::tcb_ndn_e     q_ndn,
  input  logic                  q_uns,
  input  logic [`TCB_ADR_W-1:0] q_adr,
  input  logic [`TCB_DAT_W-1:0] q_wdt,
  input  logic                  q_oor,
  // memory side
  output logic                  mem_vld,
  output logic                  mem_wen,
  output logic [`TCB_BEN-1:0]   mem_ben,
  output logic [`TCB_ADR_W-1:0] mem_adr,
  output logic [`TCB_DAT_W-1:0] mem_wdt,
  input  logic [`TCB_DAT_W-1:0] mem_rdt,
  // realigned response towards the formatter
  output logic                  al_vld,
  output logic [`TCB_DAT_W-1:0] al_rdt,
  output tcb_pkg::tcb_siz_e     al_siz,
  output logic                  al_uns,
  output logic                  al_err,
  output tcb_pkg::tcb_op_e      al_op
);

  localparam int unsigned ADR_W = `TCB_ADR_W;
  localparam int unsigned BEN   = `TCB_BEN;
  localparam int unsigned LW    = $clog2(BEN);

  // misaligned decode and combined error
  logic mal;
  logic err;
  // lane offset of the first item byte
  logic [LW-1:0] off;
  // item length in bytes, 1 to BEN
  logic [LW:0]   num;
  // bytes present in the item, low justified
  logic [BEN-1:0] itm_ben;
  // per lane: which item byte it carries
  logic [BEN-1:0][LW-1:0] sel_wdt;
  // per item byte: which lane it comes from, and its delayed copy
  logic [BEN-1:0][LW-1:0] sel_rdt;
  logic [BEN-1:0][LW-1:0] sel_rdt_q;
  // byte views of the data paths
  logic [BEN-1:0][7:0] q_wdt_b;
  logic [BEN-1:0][7:0] mem_wdt_b;
  logic [BEN-1:0][7:0] mem_rdt_b;
  logic [BEN-1:0][7:0] al_rdt_b;

  //////////////////////////////////////////////////////////////////////
  // alignment
  //////////////////////////////////////////////////////////////////////

  // same decode for loads and stores
  always_comb begin
    case (q_siz)
      tcb_pkg::siz_byte: begin
        mal = 1'b0;
        num = (LW+1)'(1);
      end
      tcb_pkg::siz_half: begin
        mal = q_adr[0];
        num = (LW+1)'(2);
      end
      tcb_pkg::siz_word: begin
        mal = |q_adr[1:0];
        num = (LW+1)'(4);
      end
      default: begin
        // illegal size code
        mal = 1'b1;
        num = (LW+1)'(BEN);
      end
    endcase
  end

  // errored requests are dropped before the memory
  assign err     = mal | q_oor;
  assign mem_vld = q_vld & ~err;
  assign mem_wen = (q_op == tcb_pkg::op_write);

  // word aligned memory address
  assign off     = q_adr[LW-1:0];
  assign mem_adr = {q_adr[ADR_W-1:LW], {LW{1'b0}}};

  //////////////////////////////////////////////////////////////////////
  // lane mapping
  //////////////////////////////////////////////////////////////////////

  assign q_wdt_b   = q_wdt;
  assign mem_wdt   = mem_wdt_b;
  assign mem_rdt_b = mem_rdt;
  assign al_rdt    = al_rdt_b;

  // selects, modulo lane count via truncation
  always_comb begin
    for (int unsigned i = 0; i < BEN; i++) begin
      if (q_ndn == tcb_pkg::ndn_big) begin
        // big endian mapping is its own inverse
        sel_wdt[i] = LW'(off + num - 1 - i);
        sel_rdt[i] = LW'(off + num - 1 - i);
      end else begin
        sel_wdt[i] = LW'(i - off);
        sel_rdt[i] = LW'(off + i);
      end
    end
  end

  // lane muxes for enables and write data
  // lanes outside the item land on item bytes >= num
  always_comb begin
    for (int unsigned k = 0; k < BEN; k++) begin
      itm_ben[k] = (k < num);
    end
    for (int unsigned i = 0; i < BEN; i++) begin
      mem_ben[i]   = itm_ben[sel_wdt[i]];
      mem_wdt_b[i] = q_wdt_b[sel_wdt[i]];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read side, one cycle behind the request
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge sub or negedge rst_n) begin
    if (!rst_n) begin
      al_vld <= 1'b0;
    end else begin
      al_vld <= q_vld;
    end
  end

  // matches the sram read latency
  always_ff @(posedge sub) begin
    if (q_vld) begin
      sel_rdt_q <= sel_rdt;
      al_siz    <= q_siz;
      al_uns    <= q_uns;
      al_err    <= err;
      al_op     <= q_op;
    end
  end

  // item bytes back to the low end
  always_comb begin
    for (int unsigned k = 0; k < BEN; k++) begin
      al_rdt_b[k] = mem_rdt_b[sel_rdt_q[k]];
    end
  end

endmodule

// File: source/tcb_rsp_fmt.sv
// tcb response formatter, sign or zero extension of loads and error data masking
`timescale 1ns/1ps
`include "tcb_cfg.svh"

module tcb_rsp_fmt (
  // realigned response from the converter
  input  logic                  al_vld,
  input  logic [`TCB_DAT_W-1:0] al_rdt,
  input  tcb_pkg::tcb_siz_e     al_siz,
  input  logic                  al_uns,
  input  logic                  al_err,
  input  tcb_pkg::tcb_op_e      al_op,
  // processor side response
  output logic                  rsp_vld,
  output logic [`TCB_DAT_W-1:0] rsp_rdt,
  output logic                  rsp_err
);

  localparam int unsigned DAT_W = `TCB_DAT_W;

  // fill bit for the upper bytes
  logic             sgn;
  // extended item before masking
  logic [DAT_W-1:0] ext;

  //////////////////////////////////////////////////////////////////////
  // extension
  //////////////////////////////////////////////////////////////////////

  // item is already low justified
  always_comb begin
    case (al_siz)
      tcb_pkg::siz_byte: begin
        sgn = al_rdt[7] & ~al_uns;
        ext = {{(DAT_W-8){sgn}}, al_rdt[7:0]};
      end
      tcb_pkg::siz_half: begin
        sgn = al_rdt[15] & ~al_uns;
        ext = {{(DAT_W-16){sgn}}, al_rdt[15:0]};
      end
      default: begin
        // full word, nothing to extend
        // illegal size never gets here without al_err
        sgn = 1'b0;
        ext = al_rdt;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////////////////////////

  assign rsp_vld = al_vld;

  // error only meaningful with the strobe
  assign rsp_err = al_vld & al_err;

  // zero data on errors and on stores
  assign rsp_rdt = (al_err || (al_op == tcb_pkg::op_write)) ? '0 : ext;

endmodule

// File: tb/tcb_mem_properties.sv
// tcb data memory assertions on response timing, error data, alignment and reset
`timescale 1ns/1ps
`include "tcb_cfg.svh"

module tcb_mem_properties (
  input logic                  sub,
  input logic                  rst_n,
  input logic                  req_vld,
  input logic                  q_vld,
  input tcb_pkg::tcb_siz_e     q_siz,
  input logic [`TCB_ADR_W-1:0] q_adr,
  input logic                  mem_vld,
  input logic                  al_vld,
  input logic                  rsp_vld,
  input logic [`TCB_DAT_W-1:0] rsp_rdt,
  input logic                  rsp_err
);

  // own misalignment decode from size and low address bits
  logic mal;
  // failed assertions so far
  int   fail_cnt = 0;

  always_comb begin
    case (q_siz)
      tcb_pkg::siz_byte: mal = 1'b0;
      tcb_pkg::siz_half: mal = q_adr[0];
      tcb_pkg::siz_word: mal = |q_adr[1:0];
      default:           mal = 1'b1;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // properties
  //////////////////////////////////////////////////////////////////////

  // fixed two cycle latency with no stalls
  rsp_latency: assert property (@(posedge sub) disable iff (!rst_n)
    rsp_vld == $past(req_vld, 2))
    else begin
      fail_cnt++;
      $error("rsp_vld does not follow req_vld by two cycles");
    end

  // error responses carry no data
  err_data_zero: assert property (@(posedge sub) disable iff (!rst_n)
    rsp_err |-> (rsp_rdt == '0))
    else begin
      fail_cnt++;
      $error("rsp_rdt nonzero on an error response");
    end

  // misaligned requests never reach the sram
  no_mal_access: assert property (@(posedge sub) disable iff (!rst_n)
    mem_vld |-> !mal)
    else begin
      fail_cnt++;
      $error("memory access issued for a misaligned request");
    end

  // whole pipeline empty under reset
  reset_quiet: assert property (@(posedge sub)
    !rst_n |-> !(q_vld || mem_vld || al_vld || rsp_vld))
    else begin
      fail_cnt++;
      $error("valid high during reset");
    end

endmodule

bind tcb_mem_top tcb_mem_properties u_props (
  .sub     (sub),     .rst_n   (rst_n),   .req_vld (req_vld),
  .q_vld   (q_vld),   .q_siz   (q_siz),   .q_adr   (q_adr),
  .mem_vld (mem_vld), .al_vld  (al_vld),  .rsp_vld (rsp_vld),
  .rsp_rdt (rsp_rdt), .rsp_err (rsp_err)
);

// File: tb/tcb_mem_tb.sv
// tcb data memory testbench with directed and random loads and stores against a shadow model
`timescale 1ns/1ps
`include "tcb_cfg.svh"

module tcb_mem_tb;

  // dut inputs
  logic                  sub;
  logic                  rst_n;
  logic                  req_vld;
  tcb_pkg::tcb_op_e      req_op;
  tcb_pkg::tcb_siz_e     req_siz;
  tcb_pkg::tcb_ndn_e     req_ndn;
  logic                  req_uns;
  logic [`TCB_ADR_W-1:0] req_adr;
  logic [`TCB_DAT_W-1:0] req_wdt;
  // dut outputs
  logic                  rsp_vld;
  logic [`TCB_DAT_W-1:0] rsp_rdt;
  logic                  rsp_err;

  // shadow of the sram with one entry per byte
  logic [7:0]  shadow [`TCB_MEM_BYTES];
  // expected responses in request order
  logic [31:0] exp_rdt [$];
  logic        exp_err [$];
  int          exp_cyc [$];
  // bookkeeping
  int          cyc;
  int          checks;
  int          errors;
  int          test_err;
  string       test_name;
  logic [31:0] rng;

  tcb_mem_top u_tcb_mem_top (
    .sub     (sub),     .rst_n   (rst_n),
    .req_vld (req_vld), .req_op  (req_op),  .req_siz (req_siz),
    .req_ndn (req_ndn), .req_uns (req_uns), .req_adr (req_adr),
    .req_wdt (req_wdt),
    .rsp_vld (rsp_vld), .rsp_rdt (rsp_rdt), .rsp_err (rsp_err)
  );

  //////////////////////////////////////////////////////////////////////
  // clock and cycle count
  //////////////////////////////////////////////////////////////////////

  initial begin
    sub = 1'b0;
    forever #2 sub = ~sub;
  end

  // read only on falling edges
  always @(posedge sub) cyc = cyc + 1;

  //////////////////////////////////////////////////////////////////////
  // helpers and reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // init pattern where every address bit shows up
  function automatic logic [31:0] fill_word(input int a);
    return {16'(a) ^ 16'hc35a, ~16'(a)};
  endfunction

  // expected response and shadow update on good stores
  function automatic void ref_access(
    input  tcb_pkg::tcb_op_e  op,
    input  tcb_pkg::tcb_siz_e siz,
    input  tcb_pkg::tcb_ndn_e ndn,
    input  logic              uns,
    input  int                adr,
    input  logic [31:0]       wdt,
    output logic [31:0]       rdt,
    output logic              err
  );
    int          n;
    int          ba;
    logic [31:0] itm;
    n   = (siz == tcb_pkg::siz_byte) ? 1 : (siz == tcb_pkg::siz_half) ? 2 :
          (siz == tcb_pkg::siz_word) ? 4 : 0;
    rdt = '0;
    itm = '0;
    // illegal size, misaligned or past the end
    if (n == 0) begin
      err = 1'b1;
    end else begin
      err = (adr % n != 0) || (adr >= `TCB_MEM_BYTES);
    end
    if (err) return;
    for (int k = 0; k < n; k++) begin
      // big endian puts item byte 0 at the highest address
      ba = (ndn == tcb_pkg::ndn_big) ? adr + n - 1 - k : adr + k;
      if (op == tcb_pkg::op_write) begin
        shadow[ba] = wdt[8*k +: 8];
      end else begin
        itm[8*k +: 8] = shadow[ba];
      end
    end
    if (op == tcb_pkg::op_write) return;
    // sign fill from the item's top bit
    if (!uns && itm[8*n-1]) begin
      for (int k = n; k < 4; k++) begin
        itm[8*k +: 8] = 8'hff;
      end
    end
    rdt = itm;
  endfunction

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // drive one strobe on this falling edge and move to the next one
  task automatic send(input tcb_pkg::tcb_op_e op, input tcb_pkg::tcb_siz_e siz,
                      input tcb_pkg::tcb_ndn_e ndn, input logic uns,
                      input logic [15:0] adr, input logic [31:0] wdt);
    logic [31:0] rdt;
    logic        err;
    ref_access(op, siz, ndn, uns, int'(adr), wdt, rdt, err);
    exp_rdt.push_back(rdt);
    exp_err.push_back(err);
    // sampled at the next rising edge and answered two falling edges on
    exp_cyc.push_back(cyc + 2);
    req_vld = 1'b1;
    req_op  = op;
    req_siz = siz;
    req_ndn = ndn;
    req_uns = uns;
    req_adr = adr;
    req_wdt = wdt;
    @(negedge sub);
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_err  = errors;
  endtask

  // stop strobing and wait out the pipeline
  task automatic finish_test();
    int t;
    req_vld = 1'b0;
    t = 0;
    while (exp_rdt.size() != 0 && t < 20) begin
      @(negedge sub);
      t++;
    end
    if (exp_rdt.size() != 0) begin
      $display("Timeout in %s: %0d responses never arrived", test_name, exp_rdt.size());
      $display("TEST FAILED");
      $finish;
    end else begin
      $display("%-24s done, %0d errors", test_name, errors - test_err);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // response checker
  //////////////////////////////////////////////////////////////////////

  always @(negedge sub) begin : compare
    logic [31:0] e_rdt;
    logic        e_err;
    int          e_cyc;
    if (rst_n && rsp_vld) begin
      if (exp_rdt.size() == 0) begin
        errors++;
        $display("Error at %0t: response with no request outstanding in %s", $time, test_name);
      end else begin
        e_rdt = exp_rdt.pop_front();
        e_err = exp_err.pop_front();
        e_cyc = exp_cyc.pop_front();
        check({test_name, " rsp_rdt"}, rsp_rdt, e_rdt);
        check({test_name, " rsp_err"}, 32'(rsp_err), 32'(e_err));
        check({test_name, " response cycle"}, 32'(cyc), 32'(e_cyc));
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [15:0] adrs [16];
    logic [15:0] adr;
    logic [31:0] dat;
    int          asrt_fails;
    rst_n   = 1'b0;
    req_vld = 1'b0;
    req_op  = tcb_pkg::op_read;
    req_siz = tcb_pkg::siz_word;
    req_ndn = tcb_pkg::ndn_little;
    req_uns = 1'b0;
    req_adr = '0;
    req_wdt = '0;
    cyc     = 0;
    checks  = 0;
    errors  = 0;
    rng     = 32'h9be26f9f;
    start_test("reset");
    repeat (16) @(posedge sub);
    @(negedge sub);
    rst_n = 1'b1;

    // 1. quiet pipeline
    start_test("idle after reset");
    repeat (8) begin
      @(negedge sub);
      check("idle rsp_vld", 32'(rsp_vld), 32'd0);
    end
    finish_test();

    // whole array defined before any load
    start_test("fill");
    for (int w = 0; w < `TCB_MEM_BYTES / 4; w++) begin
      send(tcb_pkg::op_write, tcb_pkg::siz_word, tcb_pkg::ndn_little, 1'b0,
           16'(4*w), fill_word(4*w));
    end
    finish_test();

    // 2. little endian word round trip
    start_test("word write/read");
    for (int i = 0; i < 16; i++) begin
      rng     = xorshift(rng);
      adrs[i] = 16'(rng[9:0] & 10'h3fc);
      rng     = xorshift(rng);
      send(tcb_pkg::op_write, tcb_pkg::siz_word, tcb_pkg::ndn_little, 1'b0, adrs[i], rng);
    end
    for (int i = 0; i < 16; i++) begin
      send(tcb_pkg::op_read, tcb_pkg::siz_word, tcb_pkg::ndn_little, 1'b0, adrs[i], '0);
    end
    finish_test();

    // 3. signed and unsigned sub-word loads
    start_test("byte/half extension");
    for (int i = 0; i < 6; i++) begin
      rng = xorshift(rng);
      adr = 16'(rng[9:0] & 10'h3fc);
      rng = xorshift(rng);
      // first word forces both sign cases
      dat = (i == 0) ? 32'h80f17f01 : rng;
      send(tcb_pkg::op_write, tcb_pkg::siz_word, tcb_pkg::ndn_little, 1'b0, adr, dat);
      for (int u = 0; u < 2; u++) begin
        for (int o = 0; o < 4; o++) begin
          send(tcb_pkg::op_read, tcb_pkg::siz_byte, tcb_pkg::ndn_little, 1'(u),
               adr + 16'(o), '0);
        end
        send(tcb_pkg::op_read, tcb_pkg::siz_half, tcb_pkg::ndn_little, 1'(u), adr, '0);
        send(tcb_pkg::op_read, tcb_pkg::siz_half, tcb_pkg::ndn_little, 1'(u), adr + 2, '0);
      end
    end
    finish_test();

    // 4. big endian store seen through little endian bytes
    start_test("big endian");
    adr = 16'h0100;
    send(tcb_pkg::op_write, tcb_pkg::siz_word, tcb_pkg::ndn_big, 1'b0, adr, 32'h11223344);
    for (int o = 0; o < 4; o++) begin
      send(tcb_pkg::op_read, tcb_pkg::siz_byte, tcb_pkg::ndn_little, 1'b1, adr + 16'(o), '0);
    end
    send(tcb_pkg::op_read, tcb_pkg::siz_word, tcb_pkg::ndn_big, 1'b0, adr, '0);
    send(tcb_pkg::op_read, tcb_pkg::siz_word, tcb_pkg::ndn_little, 1'b0, adr, '0);
    send(tcb_pkg::op_write, tcb_pkg::siz_half, tcb_pkg::ndn_big, 1'b0, adr + 4, 32'h8a5c);
    send(tcb_pkg::op_write, tcb_pkg::siz_half, tcb_pkg::ndn_big, 1'b0, adr + 6, 32'h1234);
    for (int u = 0; u < 2; u++) begin
      send(tcb_pkg::op_read, tcb_pkg::siz_half, tcb_pkg::ndn_big, 1'(u), adr + 4, '0);
      send(tcb_pkg::op_read, tcb_pkg::siz_half, tcb_pkg::ndn_big, 1'(u), adr + 6, '0);
      send(tcb_pkg::op_read, tcb_pkg::siz_byte, tcb_pkg::ndn_big, 1'(u), adr + 4, '0);
    end
    send(tcb_pkg::op_read, tcb_pkg::siz_word, tcb_pkg::ndn_little, 1'b0, adr + 4, '0);
    finish_test();

    // 5. errors leave memory untouched
    start_test("misaligned/out of range");
    adr = 16'h0200;
    send(tcb_pkg::op_read,  tcb_pkg::siz_half, tcb_pkg::ndn_little, 1'b0, adr + 1, '0);
    send(tcb_pkg::op_write, tcb_pkg::siz_half, tcb_pkg::ndn_big, 1'b0, adr + 3, 32'hdead);
    send(tcb_pkg::op_read,  tcb_pkg::siz_word, tcb_pkg::ndn_little, 1'b0, adr + 1, '0);
    send(tcb_pkg::op_read,  tcb_pkg::siz_word, tcb_pkg::ndn_little, 1'b0, adr + 2, '0);
    send(tcb_pkg::op_write, tcb_pkg::siz_word, tcb_pkg::ndn_little, 1'b0, adr + 3, 32'hbeef);
    send(tcb_pkg::op_write, tcb_pkg::tcb_siz_e'(2'b11), tcb_pkg::ndn_little, 1'b0, adr, '1);
    send(tcb_pkg::op_read,  tcb_pkg::siz_word, tcb_pkg::ndn_little, 1'b0, 16'd1024, '0);
    send(tcb_pkg::op_write, tcb_pkg::siz_word, tcb_pkg::ndn_little, 1'b0, 16'hfffc, '1);
    send(tcb_pkg::op_write, tcb_pkg::siz_byte, tcb_pkg::ndn_little, 1'b0, 16'd1024, '1);
    send(tcb_pkg::op_write, tcb_pkg::siz_half, tcb_pkg::ndn_little, 1'b0, 16'h8000, '1);
    // aliased words in the sram and the targets above
    send(tcb_pkg::op_read,  tcb_pkg::siz_word, tcb_pkg::ndn_little, 1'b0, adr, '0);
    send(tcb_pkg::op_read,  tcb_pkg::siz_word, tcb_pkg::ndn_little, 1'b0, adr + 4, '0);
    send(tcb_pkg::op_read,  tcb_pkg::siz_word, tcb_pkg::ndn_little, 1'b0, 16'd0, '0);
    send(tcb_pkg::op_read,  tcb_pkg::siz_word, tcb_pkg::ndn_little, 1'b0, 16'd1020, '0);
    finish_test();

    // 6. back to back random traffic
    start_test("random burst");
    for (int i = 0; i < 200; i++) begin
      rng = xorshift(rng);
      // size code 3 kept rare
      if (rng[4:3] == 2'b11 && rng[7:5] != 3'b000) begin
        req_siz = tcb_pkg::siz_word;
      end else begin
        req_siz = tcb_pkg::tcb_siz_e'(rng[4:3]);
      end
      adr = 16'(rng[31:16] % 1088);
      dat = xorshift(rng);
      send(tcb_pkg::tcb_op_e'(rng[0]), req_siz, tcb_pkg::tcb_ndn_e'(rng[1]), rng[2],
           adr, dat);
      rng = dat;
    end
    finish_test();

    // bound checker failures count as errors
    asrt_fails = u_tcb_mem_top.u_props.fail_cnt;
    if (asrt_fails != 0) begin
      errors += asrt_fails;
      $display("%0d assertion failures in the bound checker", asrt_fails);
    end

    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: tcb_mem.f
+incdir+source
source/tcb_pkg.sv
source/tcb_req_reg.sv
source/tcb_riscv2memory.sv
source/tcb_mem_sram.sv
source/tcb_rsp_fmt.sv
source/tcb_mem_top.sv
tb/tcb_mem_properties.sv
tb/tcb_mem_tb.sv
